// File: source/uce_pkg.sv
`default_nettype none

package uce_pkg;

  // fixed cache and memory geometry
  localparam int paddr_width = 32;
  localparam int block_width = 256;
  localparam int fill_width = 64;
  localparam int dword_width = 64;
  localparam int sets = 64;
  localparam int assoc = 4;
  localparam int block_beats = block_width / fill_width;
  localparam int index_width = $clog2(sets);
  localparam int way_width = $clog2(assoc);
  localparam int block_offset_width = $clog2(block_width / 8);
  localparam int fill_offset_width = $clog2(fill_width / 8);
  localparam int tag_width = paddr_width - index_width - block_offset_width;

  typedef enum logic [2:0] {
    e_miss_load,
    e_miss_store,
    e_uc_load,
    e_uc_store,
    e_cache_clear
  } req_kind_e;

  typedef enum logic [1:0] {
    e_mem_rd,
    e_mem_wr,
    e_mem_uc_rd,
    e_mem_uc_wr
  } mem_op_e;

  // set_tag always installs the line as modified
  typedef enum logic {
    e_tag_set_clear,
    e_tag_set_tag
  } tag_op_e;

  typedef enum logic {
    e_data_write,
    e_data_uncached
  } data_op_e;

  typedef enum logic [2:0] {
    e_reset,
    e_clear,
    e_ready,
    e_send_critical,
    e_read_wait,
    e_uc_read_wait
  } uce_state_e;

  typedef struct packed {
    req_kind_e                kind;
    logic [paddr_width-1:0]   addr;
    logic [1:0]               size;
    logic [dword_width-1:0]   data;
  } cache_req_s;

  typedef struct packed {
    logic [way_width-1:0]     repl_way;
  } cache_meta_s;

  typedef struct packed {
    tag_op_e                  opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
    logic [tag_width-1:0]     tag;
  } tag_pkt_s;

  typedef struct packed {
    data_op_e                 opcode;
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way_id;
    logic [block_beats-1:0]   fill_mask;
    logic [fill_width-1:0]    data;
  } data_pkt_s;

  // size is log2 of the byte count
  typedef struct packed {
    mem_op_e                  op;
    logic [paddr_width-1:0]   addr;
    logic [2:0]               size;
    logic [way_width-1:0]     way;
  } mem_hdr_s;

  typedef struct packed {
    logic [index_width-1:0]   index;
    logic [way_width-1:0]     way;
    logic [tag_width-1:0]     tag;
    logic [block_beats-1:0]   fill_mask;
    logic [fill_width-1:0]    data;
    logic                     uc;
    logic                     last;
  } fill_beat_s;

endpackage

`default_nettype wire

// File: source/uce_credit_counter.sv
`timescale 1ns/100ps
`default_nettype none

module uce_credit_counter
  #(
  parameter int max_credits_p = 4
  )
  (
  input  wire  clk_i,
  input  wire  reset_i,
  input  wire  sent_i,
  input  wire  done_i,
  output logic full_o,
  output logic empty_o
  );

  localparam int count_width = $clog2(max_credits_p + 1);

  logic [count_width-1:0] count_r;

  // simultaneous send and return cancel out
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (sent_i & ~done_i)
      count_r <= count_r + 1'b1;
    else if (done_i & ~sent_i)
      count_r <= count_r - 1'b1;
  end

  assign full_o  = (count_r == count_width'(max_credits_p));
  assign empty_o = (count_r == '0);

endmodule

`default_nettype wire

// File: source/uce_fill_in.sv
`timescale 1ns/100ps
`default_nettype none

module uce_fill_in
  import uce_pkg::*;
  (
  input  wire                    clk_i,
  input  wire                    reset_i,

  input  wire mem_hdr_s          mem_rev_hdr_i,
  input  wire [fill_width-1:0]   mem_rev_data_i,
  input  wire                    mem_rev_last_i,
  input  wire                    mem_rev_v_i,
  output logic                   mem_rev_ready_and_o,

  output fill_beat_s             beat_o,
  output logic                   beat_v_o,
  input  wire                    beat_yumi_i,

  output logic                   resp_done_o
  );

  localparam int beat_cnt_width = $clog2(block_beats);

  logic [beat_cnt_width-1:0] beat_cnt_r;
  logic [beat_cnt_width-1:0] crit_beat;
  logic [beat_cnt_width-1:0] fill_pos;
  logic                      store_resp_v;
  logic                      load_resp_v;

  assign store_resp_v = mem_rev_v_i & (mem_rev_hdr_i.op inside {e_mem_wr, e_mem_uc_wr});
  assign load_resp_v  = mem_rev_v_i & (mem_rev_hdr_i.op inside {e_mem_rd, e_mem_uc_rd});

  // write acks never wait on the cache arrays
  assign mem_rev_ready_and_o = store_resp_v | (load_resp_v & beat_yumi_i);
  assign resp_done_o = mem_rev_v_i & mem_rev_ready_and_o & mem_rev_last_i;

  // memory returns the critical beat first, then wraps around the block
  assign crit_beat = mem_rev_hdr_i.addr[fill_offset_width +: beat_cnt_width];
  assign fill_pos  = crit_beat + beat_cnt_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      beat_cnt_r <= '0;
    else if (beat_v_o & beat_yumi_i)
    begin
      if (mem_rev_last_i)
        beat_cnt_r <= '0;
      else
        beat_cnt_r <= beat_cnt_r + 1'b1;
    end
  end

  always_comb
  begin
    beat_o = '0;
    beat_o.index = mem_rev_hdr_i.addr[block_offset_width +: index_width];
    beat_o.tag   = mem_rev_hdr_i.addr[block_offset_width + index_width +: tag_width];
    beat_o.way   = mem_rev_hdr_i.way;
    beat_o.fill_mask[fill_pos] = 1'b1;
    beat_o.data  = mem_rev_data_i;
    beat_o.uc    = (mem_rev_hdr_i.op == e_mem_uc_rd);
    beat_o.last  = mem_rev_last_i;
  end

  assign beat_v_o = load_resp_v;

endmodule

`default_nettype wire

// File: source/uce_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module uce_ctrl
  import uce_pkg::*;
  (
  input  wire                    clk_i,
  input  wire                    reset_i,

  input  wire cache_req_s        cache_req_i,
  input  wire                    cache_req_v_i,
  output logic                   cache_req_yumi_o,
  output logic                   cache_req_busy_o,
  input  wire cache_meta_s       cache_meta_i,
  input  wire                    cache_meta_v_i,
  output logic                   cache_req_complete_o,
  output logic                   cache_req_critical_data_o,

  output tag_pkt_s               tag_pkt_o,
  output logic                   tag_pkt_v_o,
  input  wire                    tag_pkt_yumi_i,
  output data_pkt_s              data_pkt_o,
  output logic                   data_pkt_v_o,
  input  wire                    data_pkt_yumi_i,

  output mem_hdr_s               mem_fwd_hdr_o,
  output logic [fill_width-1:0]  mem_fwd_data_o,
  output logic                   mem_fwd_v_o,
  input  wire                    mem_fwd_ready_and_i,

  input  wire fill_beat_s        beat_i,
  input  wire                    beat_v_i,
  output logic                   beat_yumi_o,

  input  wire                    credits_full_i,
  input  wire                    credits_empty_i,
  output logic                   fwd_sent_o
  );

  localparam logic [2:0] block_size = 3'(block_offset_width);

  uce_state_e             state_r;
  uce_state_e             state_n;
  cache_req_s             cache_req_r;
  logic                   cache_req_v_r;
  cache_meta_s            cache_meta_r;
  cache_meta_s            cache_meta;
  logic [index_width-1:0] index_cnt_r;
  logic                   index_up;
  logic                   req_done;
  logic                   critical_pending_r;
  logic                   data_done_r;
  logic                   tag_done_r;
  logic                   data_acc;
  logic                   tag_acc;
  logic                   critical_sent;

  wire clear_v_li   = cache_req_v_i & (cache_req_i.kind == e_cache_clear);
  wire miss_v_r     = cache_req_v_r & (cache_req_r.kind inside {e_miss_load, e_miss_store});
  wire uc_load_v_r  = cache_req_v_r & (cache_req_r.kind == e_uc_load);
  wire uc_store_v_r = cache_req_v_r & (cache_req_r.kind == e_uc_store);

  // metadata may show up with the yumi or a cycle after it
  assign cache_meta = cache_meta_v_i ? cache_meta_i : cache_meta_r;

  assign data_acc      = data_pkt_v_o & data_pkt_yumi_i;
  assign tag_acc       = tag_pkt_v_o & tag_pkt_yumi_i;
  assign fwd_sent_o    = mem_fwd_v_o & mem_fwd_ready_and_i;
  assign critical_sent = (state_r == e_send_critical) & miss_v_r & fwd_sent_o;

  assign cache_req_busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_i;
  assign cache_req_complete_o = req_done & cache_req_v_r & ~uc_store_v_r;
  assign cache_req_critical_data_o = critical_pending_r & data_acc;

  always_comb
  begin
    state_n = state_r;
    cache_req_yumi_o = 1'b0;
    req_done = 1'b0;
    index_up = 1'b0;
    beat_yumi_o = 1'b0;
    tag_pkt_o = '0;
    tag_pkt_v_o = 1'b0;
    data_pkt_o = '0;
    data_pkt_v_o = 1'b0;
    mem_fwd_hdr_o = '0;
    mem_fwd_data_o = '0;
    mem_fwd_v_o = 1'b0;

    unique case (state_r)
      e_reset:
      begin
        state_n = e_clear;
      end
      e_clear:
      begin
        tag_pkt_o.opcode = e_tag_set_clear;
        tag_pkt_o.index = index_cnt_r;
        tag_pkt_v_o = 1'b1;
        index_up = tag_pkt_yumi_i;
        req_done = index_up & (index_cnt_r == index_width'(sets - 1));
        if (req_done)
          state_n = e_ready;
      end
      e_ready:
      begin
        // a pending uncached store goes out from here
        if (uc_store_v_r)
        begin
          mem_fwd_hdr_o.op = e_mem_uc_wr;
          mem_fwd_hdr_o.addr = cache_req_r.addr;
          mem_fwd_hdr_o.size = {1'b0, cache_req_r.size};
          mem_fwd_data_o = cache_req_r.data;
          mem_fwd_v_o = ~credits_full_i;
          req_done = fwd_sent_o;
        end
        // clear waits until no response can still touch the arrays
        cache_req_yumi_o = cache_req_v_i & ~credits_full_i
          & (~cache_req_v_r | req_done) & (~clear_v_li | credits_empty_i);
        if (cache_req_yumi_o)
        begin
          if (clear_v_li)
            state_n = e_clear;
          else if (cache_req_i.kind != e_uc_store)
            state_n = e_send_critical;
        end
      end
      e_send_critical:
      begin
        if (miss_v_r)
        begin
          mem_fwd_hdr_o.op = e_mem_rd;
          mem_fwd_hdr_o.addr = {cache_req_r.addr[paddr_width-1:fill_offset_width],
            fill_offset_width'(0)};
          mem_fwd_hdr_o.size = block_size;
          mem_fwd_hdr_o.way = cache_meta.repl_way;
          mem_fwd_v_o = ~credits_full_i;
          if (fwd_sent_o)
            state_n = e_read_wait;
        end
        else if (uc_load_v_r)
        begin
          mem_fwd_hdr_o.op = e_mem_uc_rd;
          mem_fwd_hdr_o.addr = cache_req_r.addr;
          mem_fwd_hdr_o.size = {1'b0, cache_req_r.size};
          mem_fwd_v_o = ~credits_full_i;
          if (fwd_sent_o)
            state_n = e_uc_read_wait;
        end
        else
          state_n = e_ready;
      end
      e_read_wait:
      begin
        data_pkt_o.opcode = e_data_write;
        data_pkt_o.index = beat_i.index;
        data_pkt_o.way_id = beat_i.way;
        data_pkt_o.fill_mask = beat_i.fill_mask;
        data_pkt_o.data = beat_i.data;
        data_pkt_v_o = beat_v_i & ~data_done_r;

        // tag is set once, alongside the final beat
        tag_pkt_o.opcode = e_tag_set_tag;
        tag_pkt_o.index = beat_i.index;
        tag_pkt_o.way_id = beat_i.way;
        tag_pkt_o.tag = beat_i.tag;
        tag_pkt_v_o = beat_v_i & beat_i.last & ~tag_done_r;

        beat_yumi_o = beat_v_i & (data_done_r | data_pkt_yumi_i)
          & (~beat_i.last | tag_done_r | tag_pkt_yumi_i);
        req_done = beat_yumi_o & beat_i.last;
        if (req_done)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_pkt_o.opcode = e_data_uncached;
        data_pkt_o.data = {(fill_width / dword_width){beat_i.data[dword_width-1:0]}};
        data_pkt_v_o = beat_v_i & ~data_done_r;
        beat_yumi_o = beat_v_i & (data_done_r | data_pkt_yumi_i);
        req_done = beat_yumi_o;
        if (req_done)
          state_n = e_ready;
      end
      default:
      begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_reset;
      cache_req_v_r <= 1'b0;
      index_cnt_r <= '0;
      critical_pending_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (cache_req_yumi_o)
        cache_req_v_r <= 1'b1;
      else if (req_done)
        cache_req_v_r <= 1'b0;
      // wraps to zero after the last set, ready for the next sweep
      if (index_up)
        index_cnt_r <= index_cnt_r + 1'b1;
      if (critical_sent)
        critical_pending_r <= 1'b1;
      else if (data_acc)
        critical_pending_r <= 1'b0;
    end
  end

  // remember which packets of the current beat the arrays already took
  always_ff @(posedge clk_i)
  begin
    if (reset_i | beat_yumi_o)
    begin
      data_done_r <= 1'b0;
      tag_done_r <= 1'b0;
    end
    else
    begin
      if (data_acc)
        data_done_r <= 1'b1;
      if (tag_acc)
        tag_done_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o)
      cache_req_r <= cache_req_i;
    if (cache_meta_v_i)
      cache_meta_r <= cache_meta_i;
  end

endmodule

`default_nettype wire

// File: source/uce_top.sv
`timescale 1ns/100ps
`default_nettype none

module uce_top
  import uce_pkg::*;
  #(
  parameter int max_credits_p = 4
  )
  (
  input  wire                    clk_i,
  input  wire                    reset_i,

  input  wire cache_req_s        cache_req_i,
  input  wire                    cache_req_v_i,
  output logic                   cache_req_yumi_o,
  output logic                   cache_req_busy_o,
  input  wire cache_meta_s       cache_meta_i,
  input  wire                    cache_meta_v_i,
  output logic                   cache_req_complete_o,
  output logic                   cache_req_critical_data_o,
  output logic                   cache_req_credits_full_o,
  output logic                   cache_req_credits_empty_o,

  output tag_pkt_s               tag_pkt_o,
  output logic                   tag_pkt_v_o,
  input  wire                    tag_pkt_yumi_i,
  output data_pkt_s              data_pkt_o,
  output logic                   data_pkt_v_o,
  input  wire                    data_pkt_yumi_i,

  output mem_hdr_s               mem_fwd_hdr_o,
  output logic [fill_width-1:0]  mem_fwd_data_o,
  output logic                   mem_fwd_v_o,
  input  wire                    mem_fwd_ready_and_i,

  input  wire mem_hdr_s          mem_rev_hdr_i,
  input  wire [fill_width-1:0]   mem_rev_data_i,
  input  wire                    mem_rev_last_i,
  input  wire                    mem_rev_v_i,
  output logic                   mem_rev_ready_and_o
  );

  fill_beat_s beat;
  logic       beat_v;
  logic       beat_yumi;
  logic       resp_done;
  logic       fwd_sent;

  uce_ctrl uce_ctrl_i (
    .clk_i                     (clk_i),
    .reset_i                   (reset_i),
    .cache_req_i               (cache_req_i),
    .cache_req_v_i             (cache_req_v_i),
    .cache_req_yumi_o          (cache_req_yumi_o),
    .cache_req_busy_o          (cache_req_busy_o),
    .cache_meta_i              (cache_meta_i),
    .cache_meta_v_i            (cache_meta_v_i),
    .cache_req_complete_o      (cache_req_complete_o),
    .cache_req_critical_data_o (cache_req_critical_data_o),
    .tag_pkt_o                 (tag_pkt_o),
    .tag_pkt_v_o               (tag_pkt_v_o),
    .tag_pkt_yumi_i            (tag_pkt_yumi_i),
    .data_pkt_o                (data_pkt_o),
    .data_pkt_v_o              (data_pkt_v_o),
    .data_pkt_yumi_i           (data_pkt_yumi_i),
    .mem_fwd_hdr_o             (mem_fwd_hdr_o),
    .mem_fwd_data_o            (mem_fwd_data_o),
    .mem_fwd_v_o               (mem_fwd_v_o),
    .mem_fwd_ready_and_i       (mem_fwd_ready_and_i),
    .beat_i                    (beat),
    .beat_v_i                  (beat_v),
    .beat_yumi_o               (beat_yumi),
    .credits_full_i            (cache_req_credits_full_o),
    .credits_empty_i           (cache_req_credits_empty_o),
    .fwd_sent_o                (fwd_sent)
  );

  uce_fill_in uce_fill_in_i (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .mem_rev_hdr_i       (mem_rev_hdr_i),
    .mem_rev_data_i      (mem_rev_data_i),
    .mem_rev_last_i      (mem_rev_last_i),
    .mem_rev_v_i         (mem_rev_v_i),
    .mem_rev_ready_and_o (mem_rev_ready_and_o),
    .beat_o              (beat),
    .beat_v_o            (beat_v),
    .beat_yumi_i         (beat_yumi),
    .resp_done_o         (resp_done)
  );

  uce_credit_counter #(
    .max_credits_p (max_credits_p)
  ) uce_credit_counter_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .sent_i  (fwd_sent),
    .done_i  (resp_done),
    .full_o  (cache_req_credits_full_o),
    .empty_o (cache_req_credits_empty_o)
  );

endmodule

`default_nettype wire

// File: dv/uce_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module uce_clock_gen
  (
  output logic clk_o,
  output logic reset_o
  );

  // 4 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial
  begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/uce_tb.sv
`timescale 1ns/100ps
`default_nettype none

module uce_tb
  import uce_pkg::*;
  ;

  typedef struct packed {
    req_kind_e        kind;
    logic [31:0]      addr;
    logic [1:0]       size;
    logic [63:0]      data;
    logic [1:0]       way;
    mem_op_e          exp_op;
    logic [31:0]      exp_addr;
    logic [2:0]       exp_size;
  } row_s;

  logic clk, reset;
  cache_req_s cache_req_i;
  logic cache_req_v_i, cache_req_yumi_o, cache_req_busy_o;
  cache_meta_s cache_meta_i;
  logic cache_meta_v_i, cache_req_complete_o, cache_req_critical_data_o;
  logic cache_req_credits_full_o, cache_req_credits_empty_o;
  tag_pkt_s tag_pkt_o;
  logic tag_pkt_v_o, tag_pkt_yumi_i;
  data_pkt_s data_pkt_o;
  logic data_pkt_v_o, data_pkt_yumi_i;
  mem_hdr_s mem_fwd_hdr_o;
  logic [63:0] mem_fwd_data_o;
  logic mem_fwd_v_o, mem_fwd_ready_and_i;
  mem_hdr_s mem_rev_hdr_i;
  logic [63:0] mem_rev_data_i;
  logic mem_rev_last_i, mem_rev_v_i, mem_rev_ready_and_o;

  row_s rows [5];
  tag_pkt_s tag_q [$];
  data_pkt_s data_q [$];
  mem_hdr_s fwd_q [$];
  logic [63:0] fwd_d_q [$];
  mem_hdr_s pend_q [$];
  int n_complete, n_critical, crit_pos, errors, tests, failed_tests;
  logic hold_resp;

  uce_clock_gen clock_gen_i (.clk_o(clk), .reset_o(reset));

  uce_top #(.max_credits_p(4)) uce_top_i (.clk_i(clk), .reset_i(reset), .*);

  function automatic logic [63:0] block_beat_data(logic [31:0] addr, logic [1:0] pos);
    return {addr & 32'hffff_ffe0, 28'h5a5a5a5, 2'b00, pos};
  endfunction

  task automatic check(bit ok, string msg);
    assert (ok) else
    begin
      $display("error at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic give_up(string what);
    $display("timed out waiting for %s at %0t", what, $time);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic clear_log();
    tag_q.delete();
    data_q.delete();
    fwd_q.delete();
    fwd_d_q.delete();
    n_complete = 0;
    n_critical = 0;
    crit_pos = -1;
  endtask

  // random array back-pressure
  initial
  begin
    void'($urandom(17005));
    forever
    begin
      @(posedge clk);
      tag_pkt_yumi_i <= ($urandom % 4) != 0;
      data_pkt_yumi_i <= ($urandom % 4) != 0;
    end
  end

  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (cache_req_critical_data_o)
      begin
        n_critical++;
        crit_pos = data_q.size();
      end
      if (mem_fwd_v_o && mem_fwd_ready_and_i)
      begin
        fwd_q.push_back(mem_fwd_hdr_o);
        fwd_d_q.push_back(mem_fwd_data_o);
        pend_q.push_back(mem_fwd_hdr_o);
      end
      if (tag_pkt_v_o && tag_pkt_yumi_i)
        tag_q.push_back(tag_pkt_o);
      if (data_pkt_v_o && data_pkt_yumi_i)
        data_q.push_back(data_pkt_o);
      if (cache_req_complete_o)
        n_complete++;
    end
  end

  // memory model, one message at a time
  task automatic send_response(mem_hdr_s hdr);
    int beats;
    int t;
    logic [1:0] pos;
    beats = (hdr.op == e_mem_rd) ? 4 : 1;
    for (int k = 0; k < beats; k++)
    begin
      pos = hdr.addr[4:3] + 2'(k);
      mem_rev_hdr_i <= hdr;
      mem_rev_last_i <= (k == beats - 1);
      mem_rev_v_i <= 1'b1;
      if (hdr.op == e_mem_rd)
        mem_rev_data_i <= block_beat_data(hdr.addr, pos);
      else if (hdr.op == e_mem_uc_rd)
        mem_rev_data_i <= {32'h0, hdr.addr};
      else
        mem_rev_data_i <= '0;
      t = 0;
      do
      begin
        @(posedge clk);
        t++;
        if (t > 500)
          give_up("response beat to be taken");
      end
      while (!(mem_rev_v_i && mem_rev_ready_and_o));
    end
    mem_rev_v_i <= 1'b0;
  endtask

  initial
  begin
    mem_hdr_s hdr;
    forever
    begin
      @(posedge clk);
      if (pend_q.size() > 0 && !hold_resp)
      begin
        hdr = pend_q.pop_front();
        send_response(hdr);
      end
    end
  end

  task automatic send_request(req_kind_e kind, logic [31:0] addr, logic [1:0] size,
                              logic [63:0] data, logic [1:0] way);
    int t;
    @(posedge clk);
    cache_req_i <= '{kind: kind, addr: addr, size: size, data: data};
    cache_req_v_i <= 1'b1;
    cache_meta_i <= '{repl_way: way};
    cache_meta_v_i <= 1'b1;
    t = 0;
    do
    begin
      @(posedge clk);
      t++;
      if (t > 500)
        give_up("request yumi");
    end
    while (!cache_req_yumi_o);
    cache_req_v_i <= 1'b0;
    cache_meta_v_i <= 1'b0;
  endtask

  task automatic check_sweep();
    int t;
    t = 0;
    while (tag_q.size() < 64)
    begin
      @(posedge clk);
      if (tag_q.size() < 64)
        check(cache_req_busy_o, "busy low during sweep");
      t++;
      if (t > 3000)
        give_up("sweep to finish");
    end
    @(posedge clk);
    check(!cache_req_busy_o, "busy still high after sweep");
    repeat (4) @(posedge clk);
    check(tag_q.size() == 64, $sformatf("sweep gave %0d tag packets", tag_q.size()));
    foreach (tag_q[i])
      check(tag_q[i].opcode == e_tag_set_clear && tag_q[i].index == 6'(i),
            $sformatf("sweep packet %0d has index %0d", i, tag_q[i].index));
  endtask

  task automatic wait_store_done();
    int t;
    t = 0;
    while (fwd_q.size() < 1)
    begin
      @(posedge clk);
      t++;
      if (t > 500)
        give_up("store message");
    end
    @(posedge clk);
    t = 0;
    while (!cache_req_credits_empty_o)
    begin
      @(posedge clk);
      t++;
      if (t > 500)
        give_up("credits to drain");
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic run_row(row_s r);
    int t;
    logic [1:0] pos;
    clear_log();
    send_request(r.kind, r.addr, r.size, r.data, r.way);
    if (r.kind == e_uc_store)
      wait_store_done();
    else
    begin
      t = 0;
      while (n_complete < 1)
      begin
        @(posedge clk);
        t++;
        if (t > 1000)
          give_up("complete pulse");
      end
      repeat (4) @(posedge clk);
    end
    check(fwd_q.size() == 1, $sformatf("%0d forward messages", fwd_q.size()));
    if (fwd_q.size() == 1)
    begin
      check(fwd_q[0].op == r.exp_op, "wrong forward op");
      check(fwd_q[0].addr == r.exp_addr, $sformatf("forward addr %h", fwd_q[0].addr));
      check(fwd_q[0].size == r.exp_size, "wrong forward size");
    end
    if (r.kind == e_miss_load || r.kind == e_miss_store)
    begin
      check(fwd_q.size() == 1 && fwd_q[0].way == r.way, "wrong forward way");
      check(data_q.size() == 4, $sformatf("%0d data packets", data_q.size()));
      foreach (data_q[k])
      begin
        pos = r.exp_addr[4:3] + 2'(k);
        check(data_q[k].opcode == e_data_write && data_q[k].index == r.addr[10:5]
              && data_q[k].way_id == r.way, "wrong data packet fields");
        check(data_q[k].fill_mask == 4'(1 << pos), $sformatf("beat %0d mask", k));
        check(data_q[k].data == block_beat_data(r.exp_addr, pos), "wrong fill data");
      end
      check(tag_q.size() == 1, $sformatf("%0d tag packets", tag_q.size()));
      check(tag_q.size() == 1 && tag_q[0].opcode == e_tag_set_tag
            && tag_q[0].index == r.addr[10:5] && tag_q[0].way_id == r.way
            && tag_q[0].tag == r.addr[31:11], "wrong tag packet");
      check(n_critical == 1 && crit_pos == 0, "critical data not on first write");
      check(n_complete == 1, $sformatf("%0d complete pulses", n_complete));
    end
    else if (r.kind == e_uc_load)
    begin
      check(data_q.size() == 1 && tag_q.size() == 0, "wrong packet count");
      check(data_q.size() == 1 && data_q[0].opcode == e_data_uncached
            && data_q[0].data == {32'h0, r.addr}, "wrong uncached return");
      check(n_complete == 1, $sformatf("%0d complete pulses", n_complete));
    end
    else
    begin
      check(fwd_d_q.size() == 1 && fwd_d_q[0] == r.data, "wrong store data");
      check(data_q.size() == 0 && tag_q.size() == 0, "array packet after store");
      check(n_complete == 0, "complete pulse after store");
    end
  endtask

  task automatic run_credits();
    int t;
    clear_log();
    hold_resp = 1'b1;
    for (int i = 0; i < 4; i++)
      send_request(e_uc_store, 32'h9000_0000 + 32'(i * 8), 2'd3, 64'(i), 2'd0);
    t = 0;
    while (!cache_req_credits_full_o)
    begin
      @(posedge clk);
      t++;
      if (t > 500)
        give_up("credits full");
    end
    check(fwd_q.size() == 4, $sformatf("full after %0d messages", fwd_q.size()));
    cache_req_i <= '{kind: e_uc_store, addr: 32'h9000_0040, size: 2'd3, data: 64'd4};
    cache_req_v_i <= 1'b1;
    repeat (10)
    begin
      @(posedge clk);
      check(cache_req_busy_o && !cache_req_yumi_o && !mem_fwd_v_o, "activity while full");
    end
    hold_resp = 1'b0;
    t = 0;
    while (!cache_req_yumi_o)
    begin
      @(posedge clk);
      t++;
      if (t > 500)
        give_up("yumi after release");
    end
    cache_req_v_i <= 1'b0;
    t = 0;
    while (fwd_q.size() < 5 || !cache_req_credits_empty_o)
    begin
      @(posedge clk);
      t++;
      if (t > 1000)
        give_up("credits empty");
    end
  endtask

  task automatic report(string name, int errors_before);
    tests++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
    begin
      failed_tests++;
      $display("test %s: failed", name);
    end
  endtask

  initial
  begin
    int e;
    cache_req_i <= '0;
    cache_req_v_i <= 1'b0;
    cache_meta_i <= '0;
    cache_meta_v_i <= 1'b0;
    tag_pkt_yumi_i <= 1'b0;
    data_pkt_yumi_i <= 1'b0;
    mem_fwd_ready_and_i <= 1'b1;
    mem_rev_hdr_i <= '0;
    mem_rev_data_i <= '0;
    mem_rev_last_i <= 1'b0;
    mem_rev_v_i <= 1'b0;
    hold_resp = 1'b0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    clear_log();
    rows[0] = '{e_miss_load, 32'h0001_2348, 2'd3, 64'h0, 2'd2, e_mem_rd, 32'h0001_2348, 3'd5};
    rows[1] = '{e_miss_store, 32'h0040_0a7c, 2'd2, 64'h0, 2'd1, e_mem_rd, 32'h0040_0a78, 3'd5};
    rows[2] = '{e_uc_load, 32'h8000_1004, 2'd2, 64'h0, 2'd0, e_mem_uc_rd, 32'h8000_1004, 3'd2};
    rows[3] = '{e_uc_store, 32'h8000_2010, 2'd3, 64'hdead_beef_0123_4567, 2'd0,
                e_mem_uc_wr, 32'h8000_2010, 3'd3};
    rows[4] = '{e_miss_load, 32'h7fff_ffe0, 2'd3, 64'h0, 2'd3, e_mem_rd, 32'h7fff_ffe0, 3'd5};

    e = errors;
    check_sweep();
    report("reset_sweep", e);
    foreach (rows[i])
    begin
      e = errors;
      run_row(rows[i]);
      report($sformatf("row_%0d", i), e);
    end
    e = errors;
    run_credits();
    report("credits", e);
    e = errors;
    clear_log();
    send_request(e_cache_clear, 32'h0, 2'd0, 64'h0, 2'd0);
    check_sweep();
    report("clear", e);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/uce_pkg.sv
source/uce_credit_counter.sv
source/uce_fill_in.sv
source/uce_ctrl.sv
source/uce_top.sv
dv/uce_clock_gen.sv
dv/uce_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module uce_tb -o uce_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/uce_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
  exit 1
fi

if ! grep -q "\*\*\* PASSED \*\*\*" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
